// File: hw/fpu_noncomp_pkg.sv
/*
 * Shared types for the binary64 non-computational FPU pipeline.
 * The format is fixed to IEEE-754 double and nothing here is rounded.
 * NaN payloads are never propagated; min/max of two NaNs gives CANON_NAN.
 */

package fpu_noncomp_pkg;

	//////////////////////////////////////////////////////////////////////
	// format
	//////////////////////////////////////////////////////////////////////

	localparam int FLEN = 64;
	localparam int EXP_W = 11;
	localparam int MAN_W = 52;

	// one bit per class in the fclass mask
	localparam int CLASS_W = 10;

	typedef logic [FLEN-1:0] float_t;

	// default quiet NaN, quiet bit set and empty payload
	localparam float_t CANON_NAN = 64'h7ff8_0000_0000_0000;

	//////////////////////////////////////////////////////////////////////
	// request and control
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		OP_SGNJ,
		OP_MINMAX,
		OP_CMP,
		OP_CLASS
	} fop_e;

	// variant select within an operation
	typedef logic [2:0] rm_t;

	typedef struct packed {
		fop_e op;
		rm_t rm;
		float_t opa;
		float_t opb;
	} fpu_req_t;

	typedef struct packed {
		fop_e op;
		rm_t rm;
		logic illegal;
	} fpu_ctrl_t;

	//////////////////////////////////////////////////////////////////////
	// per-operand and result flags
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic sign;
		logic zero;
		logic subnormal;
		logic normal;
		logic inf;
		logic snan;
		logic qnan;
	} fp_class_t;

	typedef struct packed {
		logic lt;
		logic eq;
		logic unordered;
	} fp_order_t;

	typedef struct packed {
		logic invalid;
		logic illegal;
	} fpu_status_t;

endpackage

// File: hw/fpu_op_decode.sv
/*
 * Stage one: captures a request whenever req_valid is high.
 * No ready or stall; one request per cycle is always accepted.
 */

`timescale 1ns/1ps

module fpu_op_decode import fpu_noncomp_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic req_valid,
	input fpu_req_t req,
	output logic dec_valid,
	output fpu_ctrl_t ctrl,
	output float_t opa,
	output float_t opb
);

	logic illegal;

	// variants outside these ranges have no defined meaning
	always_comb
	begin
		case (req.op)
			OP_SGNJ: illegal = (req.rm > 3'd2);
			OP_MINMAX: illegal = (req.rm > 3'd1);
			OP_CMP: illegal = (req.rm > 3'd2);
			default: illegal = 1'b0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			dec_valid <= 1'b0;
		else
			dec_valid <= req_valid;
	end

	// payload only moves with a valid request
	always_ff @(posedge clk)
	begin
		if (req_valid)
		begin
			ctrl <= '{op: req.op, rm: req.rm, illegal: illegal};
			opa <= req.opa;
			opb <= req.opb;
		end
	end

	// the whole pipeline keys off this bit, an X here would spread downstream
	a_dec_valid_known: assert property (@(posedge clk) disable iff (rst)
		!$isunknown(dec_valid));

endmodule

// File: hw/fpu_classify.sv
/*
 * Splits a binary64 operand into its fields and flags its class.
 * Purely combinational. The quiet bit is the top mantissa bit.
 */

`timescale 1ns/1ps

module fpu_classify import fpu_noncomp_pkg::*;
(
	input float_t x,
	output fp_class_t cls
);

	logic [EXP_W-1:0] exp_f;
	logic [MAN_W-1:0] man_f;
	logic exp_zero;
	logic exp_max;
	logic man_zero;

	assign exp_f = x[FLEN-2 -: EXP_W];
	assign man_f = x[MAN_W-1:0];
	assign exp_zero = (exp_f == '0);
	assign exp_max = (exp_f == '1);
	assign man_zero = (man_f == '0);

	assign cls.sign = x[FLEN-1];
	assign cls.zero = exp_zero & man_zero;
	assign cls.subnormal = exp_zero & ~man_zero;
	assign cls.normal = ~exp_zero & ~exp_max;
	assign cls.inf = exp_max & man_zero;
	// NaN with the quiet bit clear
	assign cls.snan = exp_max & ~man_zero & ~man_f[MAN_W-1];
	assign cls.qnan = exp_max & man_f[MAN_W-1];

	// every bit pattern falls in exactly one class
	always_comb
	begin
		if (!$isunknown(x))
			a_one_class: assert ($onehot({cls.zero, cls.subnormal, cls.normal,
				cls.inf, cls.snan, cls.qnan}));
	end

endmodule

// File: hw/fpu_order.sv
/*
 * Orders two binary64 operands without subtraction.
 * Any NaN makes the pair unordered and clears lt and eq.
 * The two zeros compare equal, so -0 is not less than +0 here.
 */

`timescale 1ns/1ps

module fpu_order import fpu_noncomp_pkg::*;
(
	input float_t a,
	input float_t b,
	input fp_class_t cls_a,
	input fp_class_t cls_b,
	output fp_order_t ord
);

	logic both_zero;
	logic any_nan;
	logic mag_lt;
	logic mag_gt;
	logic lt_raw;

	assign any_nan = cls_a.snan | cls_a.qnan | cls_b.snan | cls_b.qnan;
	assign both_zero = cls_a.zero & cls_b.zero;

	// exponent sits above mantissa, so the magnitude bits order as an unsigned integer
	assign mag_lt = (a[FLEN-2:0] < b[FLEN-2:0]);
	assign mag_gt = (a[FLEN-2:0] > b[FLEN-2:0]);

	always_comb
	begin
		if (cls_a.sign != cls_b.sign)
			lt_raw = cls_a.sign & ~both_zero;
		else if (cls_a.sign)
			lt_raw = mag_gt;
		else
			lt_raw = mag_lt;
	end

	assign ord.unordered = any_nan;
	assign ord.eq = ~any_nan & ((a == b) | both_zero);
	assign ord.lt = ~any_nan & lt_raw;

	always_comb
	begin
		if (!$isunknown({a, b}))
			a_lt_eq_excl: assert (!(ord.lt && ord.eq));
	end

endmodule

// File: hw/fpu_result_select.sv
/*
 * Stage three: forms the result word and status for each operation.
 * Illegal variants return zero with status.illegal and never raise invalid.
 * Compare results sit in bit 0; classify results in the low CLASS_W bits.
 */

`timescale 1ns/1ps

module fpu_result_select import fpu_noncomp_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic in_valid,
	input fpu_ctrl_t ctrl,
	input float_t a,
	input float_t b,
	input fp_class_t cls_a,
	input fp_class_t cls_b,
	input fp_order_t ord,
	output logic res_valid,
	output float_t res,
	output fpu_status_t status
);

	logic [CLASS_W-1:0] class_mask;
	logic a_below;
	logic cmp_bit;
	float_t nxt_res;
	fpu_status_t nxt_status;

	// fclass bit order, negative infinity first
	assign class_mask = {
		cls_a.qnan,
		cls_a.snan,
		~cls_a.sign & cls_a.inf,
		~cls_a.sign & cls_a.normal,
		~cls_a.sign & cls_a.subnormal,
		~cls_a.sign & cls_a.zero,
		cls_a.sign & cls_a.zero,
		cls_a.sign & cls_a.subnormal,
		cls_a.sign & cls_a.normal,
		cls_a.sign & cls_a.inf
	};

	// for min/max -0 sits below +0 even though they compare equal
	assign a_below = ord.lt | (cls_a.zero & cls_b.zero & cls_a.sign & ~cls_b.sign);

	always_comb
	begin
		case (ctrl.rm)
			3'd0: cmp_bit = ord.lt | ord.eq;
			3'd1: cmp_bit = ord.lt;
			default: cmp_bit = ord.eq;
		endcase
	end

	always_comb
	begin
		nxt_res = '0;
		nxt_status = '0;
		if (ctrl.illegal)
			nxt_status.illegal = 1'b1;
		else
		begin
			case (ctrl.op)
				OP_SGNJ:
				begin
					case (ctrl.rm)
						3'd0: nxt_res = {b[FLEN-1], a[FLEN-2:0]};
						3'd1: nxt_res = {~b[FLEN-1], a[FLEN-2:0]};
						default: nxt_res = {a[FLEN-1] ^ b[FLEN-1], a[FLEN-2:0]};
					endcase
				end
				OP_MINMAX:
				begin
					nxt_status.invalid = cls_a.snan | cls_b.snan;
					if (ord.unordered)
					begin
						// a lone NaN yields the other operand
						if ((cls_a.snan | cls_a.qnan) && (cls_b.snan | cls_b.qnan))
							nxt_res = CANON_NAN;
						else if (cls_a.snan | cls_a.qnan)
							nxt_res = b;
						else
							nxt_res = a;
					end
					else if (ctrl.rm[0])
						nxt_res = a_below ? b : a;
					else
						nxt_res = a_below ? a : b;
				end
				OP_CMP:
				begin
					nxt_res = {{(FLEN-1){1'b0}}, cmp_bit};
					// feq is quiet, fle and flt signal on any NaN
					if (ctrl.rm == 3'd2)
						nxt_status.invalid = cls_a.snan | cls_b.snan;
					else
						nxt_status.invalid = ord.unordered;
				end
				default:
					nxt_res = {{(FLEN-CLASS_W){1'b0}}, class_mask};
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			res_valid <= 1'b0;
			res <= '0;
			status <= '0;
		end
		else
		begin
			res_valid <= in_valid;
			if (in_valid)
			begin
				res <= nxt_res;
				status <= nxt_status;
			end
		end
	end

	a_class_onehot: assert property (@(posedge clk) disable iff (rst)
		in_valid && ctrl.op == OP_CLASS && !ctrl.illegal |=> $onehot(res[CLASS_W-1:0]));

endmodule

// File: hw/fpu_noncomp.sv
/*
 * Binary64 sign injection, classify, compare and min/max unit.
 * Three register stages, one request per cycle, results in request order.
 * There is no back-pressure; the consumer must take every result.
 */

`timescale 1ns/1ps

module fpu_noncomp import fpu_noncomp_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic req_valid,
	input fpu_req_t req,
	output logic res_valid,
	output float_t res,
	output fpu_status_t status
);

	logic dec_valid;
	fpu_ctrl_t dec_ctrl;
	float_t dec_a;
	float_t dec_b;
	fp_class_t cls_a;
	fp_class_t cls_b;
	fp_order_t ord;

	logic s2_valid;
	fpu_ctrl_t s2_ctrl;
	float_t s2_a;
	float_t s2_b;
	fp_class_t s2_cls_a;
	fp_class_t s2_cls_b;
	fp_order_t s2_ord;

	//////////////////////////////////////////////////////////////////////
	// stage one, decode
	//////////////////////////////////////////////////////////////////////

	fpu_op_decode u_decode (
		.clk(clk),
		.rst(rst),
		.req_valid(req_valid),
		.req(req),
		.dec_valid(dec_valid),
		.ctrl(dec_ctrl),
		.opa(dec_a),
		.opb(dec_b)
	);

	// classify and order are combinational off the decode registers
	fpu_classify u_cls_a (.x(dec_a), .cls(cls_a));
	fpu_classify u_cls_b (.x(dec_b), .cls(cls_b));

	fpu_order u_order (
		.a(dec_a),
		.b(dec_b),
		.cls_a(cls_a),
		.cls_b(cls_b),
		.ord(ord)
	);

	//////////////////////////////////////////////////////////////////////
	// stage two registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
			s2_valid <= 1'b0;
		else
			s2_valid <= dec_valid;
	end

	always_ff @(posedge clk)
	begin
		if (dec_valid)
		begin
			s2_ctrl <= dec_ctrl;
			s2_a <= dec_a;
			s2_b <= dec_b;
			s2_cls_a <= cls_a;
			s2_cls_b <= cls_b;
			s2_ord <= ord;
		end
	end

	// stage three registers live in the result select
	fpu_result_select u_result (
		.clk(clk),
		.rst(rst),
		.in_valid(s2_valid),
		.ctrl(s2_ctrl),
		.a(s2_a),
		.b(s2_b),
		.cls_a(s2_cls_a),
		.cls_b(s2_cls_b),
		.ord(s2_ord),
		.res_valid(res_valid),
		.res(res),
		.status(status)
	);

endmodule

// File: verification/fpu_noncomp_model.svh
/*
 * Reference model for the binary64 non-computational unit and the LFSR.
 * Included inside a module that already imports fpu_noncomp_pkg.
 * Ordering uses a signed integer key, so both zeros map to the same value.
 */

`ifndef FPU_NONCOMP_MODEL_SVH
`define FPU_NONCOMP_MODEL_SVH

typedef struct packed {
	float_t res;
	fpu_status_t status;
} expect_t;

// galois form, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(logic [31:0] s);
	if (s[0])
		return (s >> 1) ^ 32'h8020_0003;
	return s >> 1;
endfunction

function automatic logic is_nan(float_t x);
	return (x[62:52] == 11'h7ff) && (x[51:0] != '0);
endfunction

function automatic logic is_snan(float_t x);
	return is_nan(x) && !x[51];
endfunction

// position in the fclass mask
function automatic int class_index(float_t x);
	if (x[62:52] == 11'h7ff)
	begin
		if (x[51:0] == '0)
			return x[63] ? 0 : 7;
		return x[51] ? 9 : 8;
	end
	if (x[62:52] == '0)
	begin
		if (x[51:0] == '0)
			return x[63] ? 3 : 4;
		return x[63] ? 2 : 5;
	end
	return x[63] ? 1 : 6;
endfunction

// negative values map below zero, -0 and +0 share key 0
function automatic logic signed [64:0] order_key(float_t x);
	logic signed [64:0] mag;
	mag = {2'b00, x[62:0]};
	return x[63] ? -mag : mag;
endfunction

function automatic float_t model_sgnj(rm_t rm, float_t a, float_t b);
	logic s;
	case (rm)
		3'd0: s = b[63];
		3'd1: s = ~b[63];
		default: s = a[63] ^ b[63];
	endcase
	return {s, a[62:0]};
endfunction

function automatic logic model_cmp(rm_t rm, float_t a, float_t b);
	if (is_nan(a) || is_nan(b))
		return 1'b0;
	case (rm)
		3'd0: return order_key(a) <= order_key(b);
		3'd1: return order_key(a) < order_key(b);
		default: return order_key(a) == order_key(b);
	endcase
endfunction

function automatic float_t model_minmax(rm_t rm, float_t a, float_t b);
	logic a_small;
	if (is_nan(a) && is_nan(b))
		return CANON_NAN;
	if (is_nan(a))
		return b;
	if (is_nan(b))
		return a;
	a_small = (order_key(a) < order_key(b)) ||
		((order_key(a) == order_key(b)) && a[63] && !b[63]);
	if (rm == 3'd0)
		return a_small ? a : b;
	return a_small ? b : a;
endfunction

function automatic expect_t expected_result(fpu_req_t r);
	expect_t e;
	logic [2:0] rm_max;
	case (r.op)
		OP_SGNJ: rm_max = 3'd2;
		OP_MINMAX: rm_max = 3'd1;
		OP_CMP: rm_max = 3'd2;
		default: rm_max = 3'd7;
	endcase
	e = '0;
	if (r.rm > rm_max)
		e.status.illegal = 1'b1;
	else
	begin
		case (r.op)
			OP_SGNJ: e.res = model_sgnj(r.rm, r.opa, r.opb);
			OP_MINMAX:
			begin
				e.res = model_minmax(r.rm, r.opa, r.opb);
				e.status.invalid = is_snan(r.opa) || is_snan(r.opb);
			end
			OP_CMP:
			begin
				e.res = {63'b0, model_cmp(r.rm, r.opa, r.opb)};
				if (r.rm == 3'd2)
					e.status.invalid = is_snan(r.opa) || is_snan(r.opb);
				else
					e.status.invalid = is_nan(r.opa) || is_nan(r.opb);
			end
			default: e.res[class_index(r.opa)] = 1'b1;
		endcase
	end
	return e;
endfunction

`endif

// File: verification/tb_fpu_noncomp.sv
/*
 * Random testbench for the binary64 non-computational unit.
 * Each accepted request is modelled, queued and checked in order.
 * Latency is checked as exactly 3 cycles from acceptance.
 */

`timescale 1ns/1ps

module tb_fpu_noncomp import fpu_noncomp_pkg::*; ();

	`include "fpu_noncomp_model.svh"

	localparam int NUM_REQ = 2000;
	localparam int DRAIN_CYCLES = 20;
	localparam int LATENCY = 3;

	typedef struct packed {
		expect_t exp;
		logic [31:0] due;
	} pending_t;

	logic clk;
	logic rst;
	logic req_valid;
	fpu_req_t req;
	logic res_valid;
	float_t res;
	fpu_status_t status;

	logic [31:0] lfsr_state;
	logic [31:0] cycle = '0;
	pending_t pend_q[$];

	fpu_noncomp DUT (
		.clk(clk),
		.rst(rst),
		.req_valid(req_valid),
		.req(req),
		.res_valid(res_valid),
		.res(res),
		.status(status)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// random stimulus
	//////////////////////////////////////////////////////////////////////

	// one lfsr step per bit taken
	function automatic logic [63:0] rand_bits(int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[62:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
		return v;
	endfunction

	// exponent and mantissa biased toward zeros, infinities and NaNs
	function automatic float_t rand_operand();
		logic s;
		logic [10:0] e;
		logic [51:0] m;
		s = 1'(rand_bits(1));
		case (2'(rand_bits(2)))
			2'd0: e = '0;
			2'd1: e = '1;
			default: e = 11'(rand_bits(11));
		endcase
		m = (2'(rand_bits(2)) == 2'd0) ? '0 : 52'(rand_bits(52));
		return {s, e, m};
	endfunction

	function automatic fpu_req_t rand_request();
		fpu_req_t r;
		logic [1:0] sel;
		r.op = fop_e'(2'(rand_bits(2)));
		sel = 2'(rand_bits(2));
		r.rm = (sel == 2'd0) ? 3'(rand_bits(3)) : 3'(rand_bits(2));
		r.opa = rand_operand();
		// equal and sign-flipped pairs exercise the zero and eq cases
		case (3'(rand_bits(3)))
			3'd0: r.opb = r.opa;
			3'd1: r.opb = {~r.opa[63], r.opa[62:0]};
			default: r.opb = rand_operand();
		endcase
		return r;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// error reporting
	//////////////////////////////////////////////////////////////////////

	task automatic stop_on_mismatch(string name, logic [63:0] got, logic [63:0] expected);
		$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, expected);
		$display("TEST FAIL");
		$fatal(1, "mismatch on %s", name);
	endtask

	task automatic stop_on_error(string what);
		$display("ERROR at %0t: %s", $time, what);
		$display("TEST FAIL");
		$fatal(1, "%s", what);
	endtask

	//////////////////////////////////////////////////////////////////////
	// monitor and checks
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk)
	begin : monitor
		pending_t p;
		cycle = cycle + 1;
		if (rst)
		begin
			if (cycle > 1)
				assert (res_valid === 1'b0)
				else stop_on_error("res_valid high during reset");
		end
		else
		begin
			assert (!$isunknown(res_valid))
			else stop_on_error("res_valid unknown after reset");
			if (res_valid)
			begin
				assert (pend_q.size() > 0)
				else stop_on_error("res_valid with no request outstanding");
				p = pend_q.pop_front();
				assert (cycle == p.due)
				else stop_on_mismatch("result cycle", 64'(cycle), 64'(p.due));
				assert (res === p.exp.res)
				else stop_on_mismatch("res", res, p.exp.res);
				assert (status === p.exp.status)
				else stop_on_mismatch("status", 64'(status), 64'(p.exp.status));
			end
			else if (pend_q.size() > 0)
				assert (pend_q[0].due != cycle)
				else stop_on_error("res_valid low when a result was due");
			// request was driven one edge ago, its result is seen LATENCY edges from here
			if (req_valid)
			begin
				p.exp = expected_result(req);
				p.due = cycle + LATENCY;
				pend_q.push_back(p);
			end
		end
	end

	initial
	begin
		int sent;
		int waited;
		rst = 1'b1;
		req_valid = 1'b0;
		req = '0;
		lfsr_state = 32'h109a;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		sent = 0;
		while (sent < NUM_REQ)
		begin
			@(posedge clk);
			if (2'(rand_bits(2)) != 2'd0)
			begin
				req_valid <= 1'b1;
				req <= rand_request();
				sent++;
			end
			else
				req_valid <= 1'b0;
		end
		@(posedge clk);
		req_valid <= 1'b0;

		// negedge keeps the queue read clear of the monitor's updates
		waited = 0;
		while (pend_q.size() != 0 && waited < DRAIN_CYCLES)
		begin
			@(negedge clk);
			waited++;
		end
		if (pend_q.size() != 0)
		begin
			$display("ERROR: %0d results not returned within %0d cycles",
				pend_q.size(), DRAIN_CYCLES);
			$display("TEST FAIL");
			$fatal(1, "pipeline did not drain");
		end
		else
		begin
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

// File: fpu_noncomp.f
+incdir+verification
hw/fpu_noncomp_pkg.sv
hw/fpu_op_decode.sv
hw/fpu_classify.sv
hw/fpu_order.sv
hw/fpu_result_select.sv
hw/fpu_noncomp.sv
verification/tb_fpu_noncomp.sv

// File: Makefile
TOP := tb_fpu_noncomp
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile: $(OBJ)/V$(TOP)

$(OBJ)/V$(TOP): fpu_noncomp.f hw/*.sv verification/*.sv verification/*.svh
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-f fpu_noncomp.f -Mdir $(OBJ)

run: compile
	./$(OBJ)/V$(TOP) | tee sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf $(OBJ) sim.log
